// File: source/soundPkg.sv
// Shared widths, register address map and constants for the wavetable sound generator.
// Every design file refers to these by scoped name.
`default_nettype none

package soundPkg;

	typedef logic [4:0] regAddrT;
	typedef logic [3:0] nibbleT;
	typedef logic [2:0] waveSelT;
	typedef logic [19:0] phaseT;
	typedef logic [7:0] levelT;

	typedef struct packed {
		waveSelT wave;
		phaseT freq;
		nibbleT vol;
	} voiceCfgT;

	typedef struct packed {
		voiceCfgT voice0;
		voiceCfgT voice1;
		voiceCfgT voice2;
	} voiceBankT;

	typedef struct packed {
		nibbleT level0;
		nibbleT level1;
		nibbleT level2;
	} voiceLevelsT;

	localparam int SampleDiv = 8; // CCLK cycles per tick.
	localparam int BurstLen = 512; // Ticks per burst.
	localparam int BurstDecayShift = 5;
	localparam logic [15:0] LfsrSeed = 16'hACE1;
	localparam levelT Midpoint = 8'h80;

	// Register map, nibble wide data.
	localparam regAddrT AddrWave0 = 5'h05;
	localparam regAddrT AddrWave1 = 5'h0A;
	localparam regAddrT AddrWave2 = 5'h0F;
	localparam regAddrT AddrFreq0Base = 5'h10; // Five nibbles, 10..14.
	localparam regAddrT AddrVol0 = 5'h15;
	localparam regAddrT AddrFreq1Base = 5'h16; // Four nibbles, 16..19.
	localparam regAddrT AddrVol1 = 5'h1A;
	localparam regAddrT AddrFreq2Base = 5'h1B; // Four nibbles, 1B..1E.
	localparam regAddrT AddrVol2 = 5'h1F;

endpackage

`default_nettype wire

// File: source/waveTable.sv
// Rule-based table of eight 32-step waveforms, purely combinational.
`timescale 1ns/1ps
`default_nettype none

module waveTable (
	input wire soundPkg::waveSelT wave,
	input wire logic [4:0] step,
	output soundPkg::nibbleT sample
);

	always_comb begin
		case (wave)
			3'd0: sample = {4{~step[4]}}; // Square.
			3'd1: sample = step[4:1]; // Rising saw.
			3'd2: sample = ~step[4:1]; // Falling saw.
			3'd3: begin
				// Triangle, 31 - s on the way down.
				sample = step[4] ? ~step[3:0] : step[3:0];
			end
			3'd4: sample = {4{step[4:3] == 2'b00}}; // Quarter pulse.
			3'd5: sample = {4{step[4:2] == 3'b000}}; // Eighth pulse.
			3'd6: sample = {2'b00, step[4:3]} * 4'd5; // Staircase.
			default: sample = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/voiceRegs.sv
// Write-decoded register bank for the three voices.
// A nibble written with wr shows up on bank the next cycle.
`timescale 1ns/1ps
`default_nettype none

module voiceRegs (
	input wire logic CCLK,
	input wire logic rstN,
	input wire logic wr,
	input wire soundPkg::regAddrT addr,
	input wire soundPkg::nibbleT data,
	output soundPkg::voiceBankT bank
);

	always_ff @(posedge CCLK) begin
		if (!rstN) begin
			bank <= '0;
		end else if (wr) begin
			case (addr)
				soundPkg::AddrWave0: bank.voice0.wave <= data[2:0];
				soundPkg::AddrWave1: bank.voice1.wave <= data[2:0];
				soundPkg::AddrWave2: bank.voice2.wave <= data[2:0];

				soundPkg::AddrFreq0Base: bank.voice0.freq[3:0] <= data;
				soundPkg::AddrFreq0Base + 5'd1: bank.voice0.freq[7:4] <= data;
				soundPkg::AddrFreq0Base + 5'd2: bank.voice0.freq[11:8] <= data;
				soundPkg::AddrFreq0Base + 5'd3: bank.voice0.freq[15:12] <= data;
				soundPkg::AddrFreq0Base + 5'd4: bank.voice0.freq[19:16] <= data;
				soundPkg::AddrVol0: bank.voice0.vol <= data;

				// Voices 1 and 2 keep freq[3:0] at zero.
				soundPkg::AddrFreq1Base: bank.voice1.freq[7:4] <= data;
				soundPkg::AddrFreq1Base + 5'd1: bank.voice1.freq[11:8] <= data;
				soundPkg::AddrFreq1Base + 5'd2: bank.voice1.freq[15:12] <= data;
				soundPkg::AddrFreq1Base + 5'd3: bank.voice1.freq[19:16] <= data;
				soundPkg::AddrVol1: bank.voice1.vol <= data;

				soundPkg::AddrFreq2Base: bank.voice2.freq[7:4] <= data;
				soundPkg::AddrFreq2Base + 5'd1: bank.voice2.freq[11:8] <= data;
				soundPkg::AddrFreq2Base + 5'd2: bank.voice2.freq[15:12] <= data;
				soundPkg::AddrFreq2Base + 5'd3: bank.voice2.freq[19:16] <= data;
				soundPkg::AddrVol2: bank.voice2.vol <= data;

				default: ; // Unmapped.
			endcase
		end
	end

	addrKnown: assert property (@(posedge CCLK) disable iff (!rstN)
		wr |-> !$isunknown(addr))
		else $error("Write with unknown address bits.");

endmodule

`default_nettype wire

// File: source/voiceEngine.sv
// Three phase accumulators served in turn after each tick, sharing one
// table lookup and one volume multiplier.
`timescale 1ns/1ps
`default_nettype none

module voiceEngine (
	input wire logic CCLK,
	input wire logic rstN,
	input wire logic tick,
	input wire soundPkg::voiceBankT bank,
	output soundPkg::voiceLevelsT levels
);

	typedef enum logic [1:0] {
		Idle,
		Voice0,
		Voice1,
		Voice2
	} seqStateT;

	seqStateT state;
	soundPkg::phaseT phase [3];
	soundPkg::voiceCfgT cfg;
	logic [1:0] idx;
	soundPkg::phaseT nextPhase;
	logic [4:0] step;
	soundPkg::nibbleT sample;
	logic [7:0] product;

	always_comb begin
		case (state)
			Voice1: begin
				cfg = bank.voice1;
				idx = 2'd1;
			end
			Voice2: begin
				cfg = bank.voice2;
				idx = 2'd2;
			end
			default: begin
				cfg = bank.voice0;
				idx = 2'd0;
			end
		endcase
		nextPhase = phase[idx] + cfg.freq; // Wraps mod 2^20.
		step = nextPhase[19:15];
		product = sample * cfg.vol;
	end

	waveTable table0 (
		.wave(cfg.wave),
		.step(step),
		.sample(sample)
	);

	always_ff @(posedge CCLK) begin
		if (!rstN) begin
			state <= Idle;
			levels <= '0;
			for (int i = 0; i < 3; i++) begin
				phase[i] <= '0;
			end
		end else begin
			if (state != Idle) begin
				phase[idx] <= nextPhase;
			end
			case (state)
				Idle: if (tick) state <= Voice0;
				Voice0: begin
					levels.level0 <= product[7:4];
					state <= Voice1;
				end
				Voice1: begin
					levels.level1 <= product[7:4];
					state <= Voice2;
				end
				default: begin
					levels.level2 <= product[7:4];
					state <= Idle;
				end
			endcase
		end
	end

	// Divider must leave room for the three voice slots.
	tickWhileIdle: assert property (@(posedge CCLK) disable iff (!rstN)
		tick |-> state == Idle)
		else $error("Tick arrived while voices were still being updated.");

endmodule

`default_nettype wire

// File: source/burstPlayer.sv
// Crash effect. A bang starts a fixed-length LFSR noise burst whose swing
// around the midpoint decays over time, stepped once per tick.
`timescale 1ns/1ps
`default_nettype none

module burstPlayer (
	input wire logic CCLK,
	input wire logic rstN,
	input wire logic tick,
	input wire logic bang,
	output soundPkg::levelT burstLevel
);

	typedef enum logic {
		Idle,
		Playing
	} burstStateT;

	burstStateT state;
	logic pending;
	logic [8:0] count;
	logic [15:0] lfsr;
	logic [15:0] lfsrNext;
	soundPkg::nibbleT envelope;
	soundPkg::levelT swing;

	always_comb begin
		lfsrNext = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		envelope = 4'd15 - soundPkg::nibbleT'(count >> soundPkg::BurstDecayShift);
		swing = {2'b00, envelope, 2'b00}; // Envelope times 4.
	end

	always_ff @(posedge CCLK) begin
		if (!rstN) begin
			state <= Idle;
			pending <= 1'b0;
			count <= '0;
			burstLevel <= soundPkg::Midpoint;
		end else begin
			if (tick) pending <= 1'b0;
			else if (bang) pending <= 1'b1;

			if (tick) begin
				case (state)
					Idle: begin
						// The start tick only arms the burst.
						burstLevel <= soundPkg::Midpoint;
						if (pending || bang) begin
							state <= Playing;
							count <= '0;
						end
					end
					default: begin
						burstLevel <= lfsrNext[0] ? soundPkg::Midpoint + swing
							: soundPkg::Midpoint - swing;
						count <= count + 9'd1;
						if (count == soundPkg::BurstLen - 1) state <= Idle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge CCLK) begin
		if (tick) lfsr <= (state == Idle) ? soundPkg::LfsrSeed : lfsrNext;
	end

	idleMidpoint: assert property (@(posedge CCLK) disable iff (!rstN)
		state == Idle |-> burstLevel == soundPkg::Midpoint)
		else $error("Burst level left the midpoint while idle.");

	idleCountClear: assert property (@(posedge CCLK) disable iff (!rstN)
		state == Idle |-> count == '0)
		else $error("Burst counter did not wrap back to zero at the end of a burst.");

endmodule

`default_nettype wire

// File: source/soundMixer.sv
// Sample-rate divider issuing tick, and the registered mix of burst and voices.
`timescale 1ns/1ps
`default_nettype none

module soundMixer (
	input wire logic CCLK,
	input wire logic rstN,
	input wire soundPkg::voiceLevelsT levels,
	input wire soundPkg::levelT burstLevel,
	output logic tick,
	output soundPkg::levelT snd
);

	typedef logic [$clog2(soundPkg::SampleDiv)-1:0] divCntT;

	divCntT divCnt;

	always_ff @(posedge CCLK) begin
		if (!rstN) begin
			divCnt <= '0;
			tick <= 1'b0;
			snd <= soundPkg::Midpoint;
		end else begin
			tick <= 1'b0;
			if (divCnt == divCntT'(soundPkg::SampleDiv - 1)) begin
				divCnt <= '0;
				tick <= 1'b1;
			end else begin
				divCnt <= divCnt + 1'b1;
			end
			// Levels still hold the previous tick's results here.
			if (tick) begin
				snd <= burstLevel + soundPkg::levelT'(levels.level0)
					+ soundPkg::levelT'(levels.level1) + soundPkg::levelT'(levels.level2);
			end
		end
	end

	tickPulse: assert property (@(posedge CCLK) disable iff (!rstN) tick |=> !tick)
		else $error("Tick held for more than one cycle.");

endmodule

`default_nettype wire

// File: source/soundTop.sv
// Top of the sound generator: register bank, voice engine and burst player
// in parallel, mixed into snd on each sample tick.
`timescale 1ns/1ps
`default_nettype none

module soundTop (
	input wire logic CCLK,
	input wire logic rstN,
	input wire logic wr,
	input wire soundPkg::regAddrT addr,
	input wire soundPkg::nibbleT data,
	input wire logic bang,
	output soundPkg::levelT snd
);

	soundPkg::voiceBankT bank;
	soundPkg::voiceLevelsT levels;
	soundPkg::levelT burstLevel;
	logic tick;

	voiceRegs regs (
		.CCLK(CCLK),
		.rstN(rstN),
		.wr(wr),
		.addr(addr),
		.data(data),
		.bank(bank)
	);

	voiceEngine engine (
		.CCLK(CCLK),
		.rstN(rstN),
		.tick(tick),
		.bank(bank),
		.levels(levels)
	);

	burstPlayer burst (
		.CCLK(CCLK),
		.rstN(rstN),
		.tick(tick),
		.bang(bang),
		.burstLevel(burstLevel)
	);

	soundMixer mixer (
		.CCLK(CCLK),
		.rstN(rstN),
		.levels(levels),
		.burstLevel(burstLevel),
		.tick(tick),
		.snd(snd)
	);

endmodule

`default_nettype wire

// File: test/soundModel.svh
// Reference model of waveforms, voices, burst and mix, included by the sound testbench.
// The testbench steps it once per CCLK edge and once per sample tick.
`ifndef SOUNDMODEL_SVH
`define SOUNDMODEL_SVH

soundPkg::voiceBankT modelBank;
soundPkg::phaseT modelPhase [3];
soundPkg::nibbleT modelLevel [3];
logic modelPlaying;
logic modelPending;
int modelCount;
logic [15:0] modelLfsr;
soundPkg::levelT modelBurst;

function automatic int waveRule(input int w, input int s);
	case (w)
		0: return (s < 16) ? 15 : 0; // Square.
		1: return s >> 1;
		2: return 15 - (s >> 1);
		3: return (s < 16) ? s : 31 - s; // Triangle.
		4: return (s < 8) ? 15 : 0;
		5: return (s < 4) ? 15 : 0;
		6: return (s >> 3) * 5; // Staircase.
		default: return 0;
	endcase
endfunction

// Fibonacci LFSR, taps 16, 14, 13 and 11, shifting left.
function automatic logic [15:0] lfsrAdvance(input logic [15:0] v);
	logic feedback;
	feedback = v[16 - 1] ^ v[14 - 1] ^ v[13 - 1] ^ v[11 - 1];
	return {v[14:0], feedback};
endfunction

task automatic applyWrite(input soundPkg::regAddrT a, input soundPkg::nibbleT d);
	int f0;
	int f1;
	int f2;
	f0 = int'(a) - int'(soundPkg::AddrFreq0Base);
	f1 = int'(a) - int'(soundPkg::AddrFreq1Base);
	f2 = int'(a) - int'(soundPkg::AddrFreq2Base);
	if (a == soundPkg::AddrWave0) modelBank.voice0.wave = d[2:0];
	else if (a == soundPkg::AddrWave1) modelBank.voice1.wave = d[2:0];
	else if (a == soundPkg::AddrWave2) modelBank.voice2.wave = d[2:0];
	else if (a == soundPkg::AddrVol0) modelBank.voice0.vol = d;
	else if (a == soundPkg::AddrVol1) modelBank.voice1.vol = d;
	else if (a == soundPkg::AddrVol2) modelBank.voice2.vol = d;
	else if (f0 >= 0 && f0 < 5) modelBank.voice0.freq[4 * f0 +: 4] = d;
	else if (f1 >= 0 && f1 < 4) modelBank.voice1.freq[4 * f1 + 4 +: 4] = d; // Low nibble stays 0.
	else if (f2 >= 0 && f2 < 4) modelBank.voice2.freq[4 * f2 + 4 +: 4] = d;
endtask

task automatic voiceUpdate(input int v);
	soundPkg::voiceCfgT cfg;
	int s;
	cfg = (v == 0) ? modelBank.voice0 : (v == 1) ? modelBank.voice1 : modelBank.voice2;
	modelPhase[v] = modelPhase[v] + cfg.freq;
	s = modelPhase[v][19:15]; // Top 5 bits of the new phase.
	modelLevel[v] = soundPkg::nibbleT'((waveRule(cfg.wave, s) * cfg.vol) >> 4);
endtask

task automatic burstTick(input logic bangNow);
	int env;
	if (!modelPlaying) begin
		modelBurst = soundPkg::Midpoint;
		modelLfsr = soundPkg::LfsrSeed;
		if (modelPending || bangNow) begin
			modelPlaying = 1'b1;
			modelCount = 0;
		end
	end else begin
		modelLfsr = lfsrAdvance(modelLfsr);
		env = 15 - (modelCount >> soundPkg::BurstDecayShift);
		modelBurst = soundPkg::levelT'(modelLfsr[0] ? int'(soundPkg::Midpoint) + env * 4
			: int'(soundPkg::Midpoint) - env * 4);
		modelCount++;
		if (modelCount == soundPkg::BurstLen) modelPlaying = 1'b0;
	end
	modelPending = 1'b0;
endtask

function automatic soundPkg::levelT mixNow();
	return soundPkg::levelT'(int'(modelBurst) + modelLevel[0] + modelLevel[1] + modelLevel[2]);
endfunction

task automatic modelReset();
	modelBank = '0;
	for (int i = 0; i < 3; i++) begin
		modelPhase[i] = '0;
		modelLevel[i] = '0;
	end
	modelPlaying = 1'b0;
	modelPending = 1'b0;
	modelCount = 0;
	modelLfsr = '0;
	modelBurst = soundPkg::Midpoint;
endtask

`endif

// File: test/soundTb.sv
// Testbench for soundTop with directed register, waveform and burst runs, then seeded
// random traffic. Every snd sample is checked against the included model.
`timescale 1ns/1ps
`default_nettype none

module soundTb;

	localparam int TimeoutCycles = 60000; // About 6000 ticks of tests plus margin.

	logic CCLK;
	logic rstN;
	logic wr;
	logic bang;
	soundPkg::regAddrT addr;
	soundPkg::nibbleT data;
	soundPkg::levelT snd;
	soundPkg::levelT expSnd;
	integer seed;
	int errors;
	int checks;
	int tickCount;
	int relCycle;
	int voiceSlot;
	logic checkDue;

	`include "soundModel.svh"

	soundTop dut (
		.CCLK(CCLK),
		.rstN(rstN),
		.wr(wr),
		.addr(addr),
		.data(data),
		.bang(bang),
		.snd(snd)
	);

	initial begin
		CCLK = 1'b0;
		forever #4 CCLK = ~CCLK;
	end

	// Model follows the inputs as the DUT samples them on each edge.
	always @(posedge CCLK) begin
		if (!rstN) begin
			modelReset();
			relCycle = 0;
			voiceSlot = 3;
			checkDue = 1'b0;
		end else begin
			relCycle++;
			if (checkDue) begin
				checkDue = 1'b0;
				checks++;
				assert (snd === expSnd)
				else begin
					errors++;
					$display("FAILED snd expected %h actual %h", expSnd, snd);
				end
			end
			if (voiceSlot < 3) begin
				voiceUpdate(voiceSlot); // One voice per cycle after a tick.
				voiceSlot++;
			end
			if (relCycle > soundPkg::SampleDiv && relCycle % soundPkg::SampleDiv == 1) begin
				expSnd = mixNow();
				checkDue = 1'b1;
				tickCount++;
				voiceSlot = 0;
				burstTick(bang);
			end else if (bang) begin
				modelPending = 1'b1;
			end
			if (wr) applyWrite(addr, data);
		end
	end

	task automatic writeReg(input soundPkg::regAddrT a, input soundPkg::nibbleT d);
		@(posedge CCLK);
		wr <= 1'b1;
		addr <= a;
		data <= d;
		@(posedge CCLK);
		wr <= 1'b0;
	endtask

	task automatic pulseBang();
		@(posedge CCLK);
		bang <= 1'b1;
		@(posedge CCLK);
		bang <= 1'b0;
	endtask

	task automatic waitTicks(input int n);
		int target;
		@(negedge CCLK);
		target = tickCount + n;
		while (tickCount < target) @(negedge CCLK);
	endtask

	task automatic checkRegisterMap();
		writeReg(soundPkg::AddrWave0, 4'd1);
		writeReg(soundPkg::AddrFreq0Base, 4'h5);
		writeReg(soundPkg::AddrFreq0Base + 5'd1, 4'hA);
		writeReg(soundPkg::AddrFreq0Base + 5'd2, 4'h3);
		writeReg(soundPkg::AddrFreq0Base + 5'd3, 4'hC);
		writeReg(soundPkg::AddrFreq0Base + 5'd4, 4'h1);
		writeReg(soundPkg::AddrVol0, 4'hF);
		writeReg(soundPkg::AddrWave1, 4'd3);
		for (int i = 0; i < 4; i++) writeReg(soundPkg::AddrFreq1Base + 5'(i), 4'(7 - i));
		writeReg(soundPkg::AddrVol1, 4'h9);
		writeReg(soundPkg::AddrWave2, 4'd6);
		for (int i = 0; i < 4; i++) writeReg(soundPkg::AddrFreq2Base + 5'(i), 4'(2 * i + 1));
		writeReg(soundPkg::AddrVol2, 4'hC);
		waitTicks(20);
		// Low addresses other than the wave selects are unmapped.
		for (int a = 0; a < 16; a++) begin
			if (a % 5 != 0 || a == 0) writeReg(5'(a), 4'($random(seed)));
		end
		waitTicks(20);
	endtask

	task automatic sweepWaveforms();
		writeReg(soundPkg::AddrVol1, 4'h0);
		writeReg(soundPkg::AddrVol2, 4'h0);
		for (int i = 0; i < 5; i++) begin
			writeReg(soundPkg::AddrFreq0Base + 5'(i), (i == 3) ? 4'h8 : 4'h0);
		end
		writeReg(soundPkg::AddrVol0, 4'hF);
		for (int w = 0; w < 8; w++) begin
			writeReg(soundPkg::AddrWave0, 4'(w));
			waitTicks(34); // One step per tick at 2^15.
		end
	endtask

	task automatic playBursts();
		writeReg(soundPkg::AddrVol0, 4'h0);
		pulseBang();
		waitTicks(100);
		pulseBang(); // Must not restart the burst.
		waitTicks(450);
		waitTicks(20);
	endtask

	task automatic randomTraffic(input int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++) begin
			@(posedge CCLK);
			r = $random(seed);
			wr <= (r[2:0] == 3'd0);
			addr <= r[7:3];
			data <= r[11:8];
			bang <= (r[23:13] == 11'd0);
		end
		@(posedge CCLK);
		wr <= 1'b0;
		bang <= 1'b0;
	endtask

	initial begin
		seed = 66;
		errors = 0;
		checks = 0;
		tickCount = 0;
		rstN = 1'b0;
		wr = 1'b0;
		bang = 1'b0;
		addr = '0;
		data = '0;
		repeat (16) @(posedge CCLK);
		rstN <= 1'b1;
		waitTicks(3); // Idle output after reset.
		checkRegisterMap();
		sweepWaveforms();
		playBursts();
		randomTraffic(40000);
		waitTicks(2);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) $display("TEST PASS");
		else $display("TEST FAIL");
		$finish;
	end

	initial begin
		for (int n = 0; n < TimeoutCycles; n++) @(posedge CCLK);
		$display("Timeout: the run did not finish within %0d cycles.", TimeoutCycles);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
source/soundPkg.sv
source/waveTable.sv
source/voiceRegs.sv
source/voiceEngine.sv
source/burstPlayer.sv
source/soundMixer.sv
source/soundTop.sv
test/soundTb.sv
